//--- common/lsu_pkg.sv
// LSU shared definitions
package lsu_pkg;

  localparam int unsigned XLEN      = 32;
  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned ECAUSE_W  = 5;
  localparam int unsigned ROB_IDX_W = 6;

  typedef enum logic [1:0] {
    LSU_LW,
    LSU_LB,
    LSU_LBU,
    LSU_SW
  } lsu_op_e;

  // Exception causes
  localparam logic [ECAUSE_W-1:0] ECAUSE_LD_MISALIGN = 5'd4;
  localparam logic [ECAUSE_W-1:0] ECAUSE_LD_FAULT    = 5'd5;
  localparam logic [ECAUSE_W-1:0] ECAUSE_ST_MISALIGN = 5'd6;

  // Load request, lane id travels as the arbiter grant
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    lsu_op_e           op;
  } ld_req_t;

  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      data;
    logic                 exc;
    logic [ECAUSE_W-1:0]  cause;
  } wb_t;

endpackage

//--- lsu/lsu_arbiter.sv
// Fixed-priority lane arbiter
`timescale 1ns/10ps

module lsu_arbiter #(
  parameter int unsigned N_LSU = 2,
  parameter type payload_t = logic,
  localparam int unsigned IDX_W = (N_LSU <= 1) ? 1 : $clog2(N_LSU)
) (
  input  logic [N_LSU-1:0] valid_i,
  input  payload_t         payload_i [N_LSU],
  input  logic             ready_i,
  output logic             valid_o,
  output payload_t         payload_o,
  output logic [IDX_W-1:0] grant_idx_o,
  output logic [N_LSU-1:0] ready_o
);

  // Lowest index wins
  always_comb begin
    valid_o     = 1'b0;
    grant_idx_o = '0;
    for (int i = 0; i < N_LSU; i++) begin
      if (valid_i[i] && !valid_o) begin
        valid_o     = 1'b1;
        grant_idx_o = IDX_W'(i);
      end
    end
  end

  assign payload_o = payload_i[grant_idx_o];

  always_comb begin
    ready_o = '0;
    if (valid_o) begin
      ready_o[grant_idx_o] = ready_i;
    end
  end

endmodule

//--- lsu/lsu_lane.sv
// Load/store lane
`timescale 1ns/10ps

module lsu_lane import lsu_pkg::*; #(
  parameter int unsigned SB_DEPTH = 8,
  localparam int unsigned SB_IDX_W = $clog2(SB_DEPTH)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_op_e              op_i,
  input  logic [ADDR_W-1:0]    addr_i,
  input  logic [XLEN-1:0]      st_data_i,
  input  logic [ROB_IDX_W-1:0] rob_idx_i,
  input  logic [SB_IDX_W-1:0]  sb_id_i,

  output logic                 sb_fill_o,
  output logic [SB_IDX_W-1:0]  sb_slot_o,
  output logic [ADDR_W-1:0]    sb_addr_o,
  output logic [XLEN-1:0]      sb_data_o,
  output logic [ADDR_W-1:0]    fwd_addr_o,
  input  logic                 fwd_hit_i,
  input  logic [XLEN-1:0]      fwd_data_i,

  output logic                 ld_req_valid_o,
  output ld_req_t              ld_req_o,
  input  logic                 ld_req_ready_i,
  input  logic                 ld_rsp_valid_i,
  output logic                 ld_rsp_ready_o,
  input  logic [XLEN-1:0]      ld_rsp_data_i,
  input  logic                 ld_rsp_err_i,

  output logic                 wb_valid_o,
  output wb_t                  wb_o,
  input  logic                 wb_ready_i
);

  typedef enum logic [1:0] {IDLE, LD_REQ, LD_WAIT, WB} state_e;

  state_e               state_q;
  lsu_op_e              op_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [XLEN-1:0]      word_q;
  logic [XLEN-1:0]      result;
  logic [ROB_IDX_W-1:0] rob_q;
  logic [SB_IDX_W-1:0]  slot_q;
  logic [ECAUSE_W-1:0]  cause_q;
  logic [7:0]           byte_sel;
  logic                 exc_q;
  logic                 fill_q;
  logic                 accept;
  logic                 misalign;
  logic                 rsp_fire;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign misalign    = ((op_i == LSU_LW) || (op_i == LSU_SW)) && (addr_i[1:0] != 2'b00);
  assign rsp_fire    = ld_rsp_valid_i && ld_rsp_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      fill_q  <= 1'b0;
    end else begin
      // Fill lands in the first WB cycle of an aligned store
      fill_q <= accept && !misalign && (op_i == LSU_SW);
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= (misalign || (op_i == LSU_SW) || fwd_hit_i) ? WB : LD_REQ;
          end
        end
        LD_REQ:  if (ld_req_ready_i) state_q <= LD_WAIT;
        LD_WAIT: if (ld_rsp_valid_i) state_q <= WB;
        WB:      if (wb_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= op_i;
      addr_q  <= addr_i;
      rob_q   <= rob_idx_i;
      slot_q  <= sb_id_i;
      exc_q   <= misalign;
      cause_q <= (op_i == LSU_SW) ? ECAUSE_ST_MISALIGN : ECAUSE_LD_MISALIGN;
      word_q  <= (op_i == LSU_SW) ? st_data_i : fwd_data_i;
    end else if (rsp_fire) begin
      word_q  <= ld_rsp_data_i;
      exc_q   <= ld_rsp_err_i;
      cause_q <= ECAUSE_LD_FAULT;
    end
  end

  assign fwd_addr_o = addr_i;
  assign sb_fill_o  = fill_q;
  assign sb_slot_o  = slot_q;
  assign sb_addr_o  = addr_q;
  assign sb_data_o  = word_q;

  assign ld_req_valid_o = (state_q == LD_REQ);
  assign ld_req_o.addr  = addr_q;
  assign ld_req_o.op    = op_q;
  assign ld_rsp_ready_o = (state_q == LD_WAIT);

  // Byte lane select and extension
  assign byte_sel = word_q[{addr_q[1:0], 3'b000} +: 8];

  always_comb begin
    case (op_q)
      LSU_LB:  result = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      LSU_LBU: result = {{(XLEN-8){1'b0}}, byte_sel};
      LSU_LW:  result = word_q;
      default: result = '0;
    endcase
  end

  assign wb_valid_o    = (state_q == WB);
  assign wb_o.rob_idx  = rob_q;
  assign wb_o.data     = exc_q ? '0 : result;
  assign wb_o.exc      = exc_q;
  assign wb_o.cause    = exc_q ? cause_q : '0;

endmodule

//--- lsu/lsu_group.sv
// Load/store lane group
`timescale 1ns/10ps

module lsu_group import lsu_pkg::*; #(
  parameter int unsigned N_LSU    = 2,
  parameter int unsigned SB_DEPTH = 8,
  localparam int unsigned SB_IDX_W = $clog2(SB_DEPTH),
  localparam int unsigned ID_W     = (N_LSU <= 1) ? 1 : $clog2(N_LSU)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_op_e              op_i,
  input  logic [XLEN-1:0]      base_i,
  input  logic [XLEN-1:0]      offset_i,
  input  logic [XLEN-1:0]      st_data_i,
  input  logic [ROB_IDX_W-1:0] rob_idx_i,
  input  logic [SB_IDX_W-1:0]  sb_id_i,

  output logic                 sb_fill_o,
  output logic [SB_IDX_W-1:0]  sb_slot_o,
  output logic [ADDR_W-1:0]    sb_addr_o,
  output logic [XLEN-1:0]      sb_data_o,
  output logic [ADDR_W-1:0]    fwd_addr_o,
  input  logic                 fwd_hit_i,
  input  logic [XLEN-1:0]      fwd_data_i,

  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output logic [ADDR_W-1:0]    mem_req_addr_o,
  output logic [ID_W-1:0]      mem_req_id_o,
  input  logic                 mem_rsp_valid_i,
  output logic                 mem_rsp_ready_o,
  input  logic [ID_W-1:0]      mem_rsp_id_i,
  input  logic [XLEN-1:0]      mem_rsp_data_i,
  input  logic                 mem_rsp_err_i,

  output logic                 wb_valid_o,
  output wb_t                  wb_o,
  input  logic                 wb_ready_i
);

  logic [XLEN-1:0]     ea_full;
  logic [N_LSU-1:0]    lane_ready;
  logic [N_LSU-1:0]    lane_req_valid;
  logic [N_LSU-1:0]    lane_fill;
  logic [N_LSU-1:0]    lane_ld_valid;
  logic [N_LSU-1:0]    lane_ld_ready;
  logic [N_LSU-1:0]    lane_rsp_valid;
  logic [N_LSU-1:0]    lane_rsp_ready;
  logic [N_LSU-1:0]    lane_wb_valid;
  logic [N_LSU-1:0]    lane_wb_ready;
  logic [SB_IDX_W-1:0] lane_slot     [N_LSU];
  logic [ADDR_W-1:0]   lane_sb_addr  [N_LSU];
  logic [XLEN-1:0]     lane_sb_data  [N_LSU];
  ld_req_t             lane_ld_req   [N_LSU];
  wb_t                 lane_wb       [N_LSU];
  ld_req_t             mem_req;
  logic                alloc_found;

  assign ea_full = base_i + offset_i;

  for (genvar g = 0; g < N_LSU; g++) begin : g_lane
    lsu_lane #(
      .SB_DEPTH(SB_DEPTH)
    ) u_lane (
      .clk_i,
      .rst_n_i,
      .req_valid_i   (lane_req_valid[g]),
      .req_ready_o   (lane_ready[g]),
      .op_i,
      .addr_i        (ea_full[ADDR_W-1:0]),
      .st_data_i,
      .rob_idx_i,
      .sb_id_i,
      .sb_fill_o     (lane_fill[g]),
      .sb_slot_o     (lane_slot[g]),
      .sb_addr_o     (lane_sb_addr[g]),
      .sb_data_o     (lane_sb_data[g]),
      .fwd_addr_o    (),
      .fwd_hit_i,
      .fwd_data_i,
      .ld_req_valid_o(lane_ld_valid[g]),
      .ld_req_o      (lane_ld_req[g]),
      .ld_req_ready_i(lane_ld_ready[g]),
      .ld_rsp_valid_i(lane_rsp_valid[g]),
      .ld_rsp_ready_o(lane_rsp_ready[g]),
      .ld_rsp_data_i (mem_rsp_data_i),
      .ld_rsp_err_i  (mem_rsp_err_i),
      .wb_valid_o    (lane_wb_valid[g]),
      .wb_o          (lane_wb[g]),
      .wb_ready_i    (lane_wb_ready[g])
    );
  end

  // ========================================
  // Allocation and store buffer muxing
  // ========================================
  assign req_ready_o = |lane_ready;

  // Accepting lane queries with the shared effective address
  assign fwd_addr_o = ea_full[ADDR_W-1:0];

  always_comb begin
    alloc_found    = 1'b0;
    lane_req_valid = '0;
    for (int i = 0; i < N_LSU; i++) begin
      if (lane_ready[i] && !alloc_found) begin
        alloc_found       = 1'b1;
        lane_req_valid[i] = req_valid_i;
      end
    end
  end

  // Downward scan so the lowest pulsing lane is left standing
  always_comb begin
    sb_fill_o = 1'b0;
    sb_slot_o = lane_slot[0];
    sb_addr_o = lane_sb_addr[0];
    sb_data_o = lane_sb_data[0];
    for (int i = N_LSU - 1; i >= 0; i--) begin
      if (lane_fill[i]) begin
        sb_fill_o = 1'b1;
        sb_slot_o = lane_slot[i];
        sb_addr_o = lane_sb_addr[i];
        sb_data_o = lane_sb_data[i];
      end
    end
  end

  // ========================================
  // Memory path and writeback
  // ========================================
  lsu_arbiter #(
    .N_LSU    (N_LSU),
    .payload_t(ld_req_t)
  ) u_ld_arb (
    .valid_i    (lane_ld_valid),
    .payload_i  (lane_ld_req),
    .ready_i    (mem_req_ready_i),
    .valid_o    (mem_req_valid_o),
    .payload_o  (mem_req),
    .grant_idx_o(mem_req_id_o),
    .ready_o    (lane_ld_ready)
  );

  assign mem_req_addr_o = mem_req.addr;

  always_comb begin
    lane_rsp_valid  = '0;
    mem_rsp_ready_o = 1'b0;
    if (mem_rsp_valid_i && (mem_rsp_id_i < N_LSU)) begin
      lane_rsp_valid[mem_rsp_id_i] = 1'b1;
      mem_rsp_ready_o              = lane_rsp_ready[mem_rsp_id_i];
    end
  end

  lsu_arbiter #(
    .N_LSU    (N_LSU),
    .payload_t(wb_t)
  ) u_wb_arb (
    .valid_i    (lane_wb_valid),
    .payload_i  (lane_wb),
    .ready_i    (wb_ready_i),
    .valid_o    (wb_valid_o),
    .payload_o  (wb_o),
    .grant_idx_o(),
    .ready_o    (lane_wb_ready)
  );

endmodule

//--- verilog/store_buffer.sv
// Store buffer with forwarding
`timescale 1ns/10ps

module store_buffer import lsu_pkg::*; #(
  parameter int unsigned SB_DEPTH = 8,
  localparam int unsigned SB_IDX_W = $clog2(SB_DEPTH)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                fill_i,
  input  logic [SB_IDX_W-1:0] slot_i,
  input  logic [ADDR_W-1:0]   fill_addr_i,
  input  logic [XLEN-1:0]     fill_data_i,
  input  logic [ADDR_W-1:0]   fwd_addr_i,
  input  logic                commit_i,
  output logic                fwd_hit_o,
  output logic [XLEN-1:0]     fwd_data_o,
  output logic                drain_o,
  output logic [ADDR_W-1:0]   drain_addr_o,
  output logic [XLEN-1:0]     drain_data_o
);

  logic [SB_DEPTH-1:0] filled_q;
  logic [ADDR_W-1:0]   addr_q [SB_DEPTH];
  logic [XLEN-1:0]     data_q [SB_DEPTH];
  logic [SB_IDX_W-1:0] head_q;
  logic [SB_IDX_W-1:0] idx;
  logic                run;

  // Walk from the head over the filled run, the last match is the youngest
  always_comb begin
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    run        = 1'b1;
    idx        = head_q;
    for (int i = 0; i < SB_DEPTH; i++) begin
      idx = head_q + SB_IDX_W'(i);
      run = run && filled_q[idx];
      if (run && (addr_q[idx][ADDR_W-1:2] == fwd_addr_i[ADDR_W-1:2])) begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = data_q[idx];
      end
    end
  end

  // Unfilled head ignores commit
  assign drain_o      = commit_i && filled_q[head_q];
  assign drain_addr_o = addr_q[head_q];
  assign drain_data_o = data_q[head_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      filled_q <= '0;
      head_q   <= '0;
    end else begin
      if (drain_o) begin
        filled_q[head_q] <= 1'b0;
        head_q           <= head_q + 1'b1;
      end
      if (fill_i) begin
        filled_q[slot_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      addr_q[slot_i] <= fill_addr_i;
      data_q[slot_i] <= fill_data_i;
    end
  end

endmodule

//--- verilog/data_mem.sv
// Word data memory
`timescale 1ns/10ps

module data_mem import lsu_pkg::*; #(
  parameter int unsigned MEM_WORDS = 256,
  parameter int unsigned N_LSU     = 2,
  localparam int unsigned ID_W      = (N_LSU <= 1) ? 1 : $clog2(N_LSU),
  localparam int unsigned MEM_IDX_W = (MEM_WORDS <= 1) ? 1 : $clog2(MEM_WORDS)
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  logic [ID_W-1:0]   req_id_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output logic [ID_W-1:0]   rsp_id_o,
  output logic [XLEN-1:0]   rsp_data_o,
  output logic              rsp_err_o,
  input  logic              wr_en_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [XLEN-1:0]   wr_data_i
);

  logic [XLEN-1:0]   mem_q [MEM_WORDS];
  logic [ADDR_W-3:0] rd_word;
  logic [ADDR_W-3:0] wr_word;
  logic              rd_err;
  logic              req_fire;

  assign rd_word     = req_addr_i[ADDR_W-1:2];
  assign wr_word     = wr_addr_i[ADDR_W-1:2];
  assign rd_err      = (rd_word >= MEM_WORDS);
  assign req_ready_o = !rsp_valid_o;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (req_fire) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
      if (wr_en_i && (wr_word < MEM_WORDS)) begin
        mem_q[wr_word[MEM_IDX_W-1:0]] <= wr_data_i;
      end
    end
  end

  // Response held until taken
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_id_o   <= req_id_i;
      rsp_err_o  <= rd_err;
      rsp_data_o <= rd_err ? '0 : mem_q[rd_word[MEM_IDX_W-1:0]];
    end
  end

endmodule

//--- verilog/lsu_top.sv
// LSU subsystem top
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned N_LSU     = 2,
  parameter int unsigned SB_DEPTH  = 8,
  parameter int unsigned MEM_WORDS = 256,
  localparam int unsigned SB_IDX_W = $clog2(SB_DEPTH),
  localparam int unsigned ID_W     = (N_LSU <= 1) ? 1 : $clog2(N_LSU)
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  lsu_op_e              op_i,
  input  logic [XLEN-1:0]      base_i,
  input  logic [XLEN-1:0]      offset_i,
  input  logic [XLEN-1:0]      st_data_i,
  input  logic [ROB_IDX_W-1:0] rob_idx_i,
  input  logic [SB_IDX_W-1:0]  sb_id_i,
  input  logic                 commit_i,
  output logic                 wb_valid_o,
  input  logic                 wb_ready_i,
  output logic [ROB_IDX_W-1:0] wb_rob_idx_o,
  output logic [XLEN-1:0]      wb_data_o,
  output logic                 wb_exc_o,
  output logic [ECAUSE_W-1:0]  wb_cause_o
);

  logic                sb_fill;
  logic [SB_IDX_W-1:0] sb_slot;
  logic [ADDR_W-1:0]   sb_addr;
  logic [XLEN-1:0]     sb_data;
  logic [ADDR_W-1:0]   fwd_addr;
  logic                fwd_hit;
  logic [XLEN-1:0]     fwd_data;
  logic                mem_req_valid;
  logic                mem_req_ready;
  logic [ADDR_W-1:0]   mem_req_addr;
  logic [ID_W-1:0]     mem_req_id;
  logic                mem_rsp_valid;
  logic                mem_rsp_ready;
  logic [ID_W-1:0]     mem_rsp_id;
  logic [XLEN-1:0]     mem_rsp_data;
  logic                mem_rsp_err;
  logic                drain;
  logic [ADDR_W-1:0]   drain_addr;
  logic [XLEN-1:0]     drain_data;
  wb_t                 wb;

  lsu_group #(
    .N_LSU   (N_LSU),
    .SB_DEPTH(SB_DEPTH)
  ) u_group (
    .clk_i, .rst_n_i,
    .req_valid_i, .req_ready_o, .op_i, .base_i, .offset_i, .st_data_i, .rob_idx_i, .sb_id_i,
    .sb_fill_o      (sb_fill),
    .sb_slot_o      (sb_slot),
    .sb_addr_o      (sb_addr),
    .sb_data_o      (sb_data),
    .fwd_addr_o     (fwd_addr),
    .fwd_hit_i      (fwd_hit),
    .fwd_data_i     (fwd_data),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_ready_i(mem_req_ready),
    .mem_req_addr_o (mem_req_addr),
    .mem_req_id_o   (mem_req_id),
    .mem_rsp_valid_i(mem_rsp_valid),
    .mem_rsp_ready_o(mem_rsp_ready),
    .mem_rsp_id_i   (mem_rsp_id),
    .mem_rsp_data_i (mem_rsp_data),
    .mem_rsp_err_i  (mem_rsp_err),
    .wb_valid_o,
    .wb_o           (wb),
    .wb_ready_i
  );

  store_buffer #(
    .SB_DEPTH(SB_DEPTH)
  ) u_sb (
    .clk_i, .rst_n_i,
    .fill_i      (sb_fill),
    .slot_i      (sb_slot),
    .fill_addr_i (sb_addr),
    .fill_data_i (sb_data),
    .fwd_addr_i  (fwd_addr),
    .commit_i,
    .fwd_hit_o   (fwd_hit),
    .fwd_data_o  (fwd_data),
    .drain_o     (drain),
    .drain_addr_o(drain_addr),
    .drain_data_o(drain_data)
  );

  data_mem #(
    .MEM_WORDS(MEM_WORDS),
    .N_LSU    (N_LSU)
  ) u_mem (
    .clk_i, .rst_n_i,
    .req_valid_i(mem_req_valid),
    .req_ready_o(mem_req_ready),
    .req_addr_i (mem_req_addr),
    .req_id_i   (mem_req_id),
    .rsp_valid_o(mem_rsp_valid),
    .rsp_ready_i(mem_rsp_ready),
    .rsp_id_o   (mem_rsp_id),
    .rsp_data_o (mem_rsp_data),
    .rsp_err_o  (mem_rsp_err),
    .wr_en_i    (drain),
    .wr_addr_i  (drain_addr),
    .wr_data_i  (drain_data)
  );

  assign wb_rob_idx_o = wb.rob_idx;
  assign wb_data_o    = wb.data;
  assign wb_exc_o     = wb.exc;
  assign wb_cause_o   = wb.cause;

endmodule

//--- verif/lsu_top_asserts.sv
// LSU handshake assertions
`timescale 1ns/10ps

module lsu_top_asserts import lsu_pkg::*; #(
  parameter int unsigned N_LSU = 2
) (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic [N_LSU-1:0] lane_wb_valid_i,
  input logic [N_LSU-1:0] lane_wb_ready_i,
  input wb_t              lane_wb_i [N_LSU],
  input logic             mem_req_fire_i,
  input logic             mem_rsp_valid_i,
  input logic             sb_fill_i
);

  bit fail_seen = 1'b0;

  // Each lane keeps its writeback until the arbiter and the wb port take it
  for (genvar g = 0; g < N_LSU; g++) begin : g_wb
    wb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      lane_wb_valid_i[g] && !lane_wb_ready_i[g] |=>
        lane_wb_valid_i[g] && $stable(lane_wb_i[g]))
      else begin
        fail_seen = 1'b1;
        $error("lane writeback payload changed before it was taken");
      end
  end

  // Response needs a request accepted the cycle before
  rsp_after_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_rsp_valid_i) |-> $past(mem_req_fire_i))
    else begin
      fail_seen = 1'b1;
      $error("memory response appeared without a request");
    end

  fill_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sb_fill_i |=> !sb_fill_i)
    else begin
      fail_seen = 1'b1;
      $error("store buffer fill lasted more than one cycle");
    end

endmodule

bind lsu_top lsu_top_asserts #(
  .N_LSU(N_LSU)
) u_asserts (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .lane_wb_valid_i(u_group.lane_wb_valid),
  .lane_wb_ready_i(u_group.lane_wb_ready),
  .lane_wb_i      (u_group.lane_wb),
  .mem_req_fire_i (mem_req_valid && mem_req_ready),
  .mem_rsp_valid_i(mem_rsp_valid),
  .sb_fill_i      (sb_fill)
);

//--- verif/tb_lsu_top.sv
// LSU subsystem testbench
`timescale 1ns/10ps

module tb_lsu_top import lsu_pkg::*; ();

  localparam int unsigned N_LSU      = 2;
  localparam int unsigned SB_DEPTH   = 8;
  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned N_OPS      = 400;
  localparam int unsigned MAX_CYCLES = N_OPS * 40;
  localparam int unsigned SB_IDX_W   = $clog2(SB_DEPTH);
  localparam int unsigned ROB_N      = 1 << ROB_IDX_W;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  lsu_op_e              op_i;
  logic [XLEN-1:0]      base_i;
  logic [XLEN-1:0]      offset_i;
  logic [XLEN-1:0]      st_data_i;
  logic [ROB_IDX_W-1:0] rob_idx_i;
  logic [SB_IDX_W-1:0]  sb_id_i;
  logic                 commit_i;
  logic                 wb_valid_o;
  logic                 wb_ready_i;
  logic [ROB_IDX_W-1:0] wb_rob_idx_o;
  logic [XLEN-1:0]      wb_data_o;
  logic                 wb_exc_o;
  logic [ECAUSE_W-1:0]  wb_cause_o;

  integer               seed = 32'h48b21034;
  logic [XLEN-1:0]      model_mem [MEM_WORDS];
  logic [ADDR_W-1:0]    pend_addr [$];
  logic [XLEN-1:0]      pend_data [$];
  wb_t                  exp_wb [ROB_N];
  bit                   exp_live [ROB_N];
  int                   outstanding = 0;
  int                   issued = 0;
  int                   sent = 0;
  int                   cycles = 0;
  int                   first_acc = 0;
  bit                   store_busy = 1'b0;
  bit                   wb_hold = 1'b1;
  bit                   check_ready = 1'b0;
  bit                   acc_s = 1'b0;
  bit                   wb_s = 1'b0;
  wb_t                  wb_val;
  logic [ROB_IDX_W-1:0] rob_next = '0;
  logic [SB_IDX_W-1:0]  slot_next = '0;
  logic [ROB_IDX_W-1:0] store_rob;
  logic [ADDR_W-1:0]    store_addr;
  logic [XLEN-1:0]      store_data;

  lsu_top #(
    .N_LSU    (N_LSU),
    .SB_DEPTH (SB_DEPTH),
    .MEM_WORDS(MEM_WORDS)
  ) i_dut (
    .clk_i, .rst_n_i, .req_valid_i, .req_ready_o, .op_i, .base_i, .offset_i,
    .st_data_i, .rob_idx_i, .sb_id_i, .commit_i, .wb_valid_o, .wb_ready_i,
    .wb_rob_idx_o, .wb_data_o, .wb_exc_o, .wb_cause_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic wb_t load_result(lsu_op_e op, logic [ADDR_W-1:0] addr,
                                      logic [ROB_IDX_W-1:0] rob);
    wb_t             r;
    logic [XLEN-1:0] word;
    logic [7:0]      b;
    logic            hit;
    r.rob_idx = rob;
    r.data    = '0;
    r.exc     = 1'b0;
    r.cause   = '0;
    hit       = 1'b0;
    word      = '0;
    // Later entries are younger
    foreach (pend_addr[i]) begin
      if (pend_addr[i][ADDR_W-1:2] == addr[ADDR_W-1:2]) begin
        hit  = 1'b1;
        word = pend_data[i];
      end
    end
    if (op == LSU_LW && addr[1:0] != 2'b00) begin
      r.exc   = 1'b1;
      r.cause = ECAUSE_LD_MISALIGN;
    end else if (!hit && addr[ADDR_W-1:2] >= MEM_WORDS) begin
      r.exc   = 1'b1;
      r.cause = ECAUSE_LD_FAULT;
    end else begin
      if (!hit) begin
        word = model_mem[addr[ADDR_W-1:2]];
      end
      b = word[8*addr[1:0] +: 8];
      case (op)
        LSU_LB:  r.data = {{(XLEN-8){b[7]}}, b};
        LSU_LBU: r.data = {{(XLEN-8){1'b0}}, b};
        default: r.data = word;
      endcase
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    if (exp !== act) begin
      $display("error %s: expected %0h, actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic process_events();
    wb_t               exp;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-3:0] word;
    addr = ADDR_W'(base_i + offset_i);
    if (acc_s) begin
      if (exp_live[rob_idx_i]) begin
        $display("ROB index %0d issued again while still outstanding", rob_idx_i);
        abort_run();
      end
      if (op_i == LSU_SW) begin
        exp.rob_idx = rob_idx_i;
        exp.data    = '0;
        exp.exc     = (addr[1:0] != 2'b00);
        exp.cause   = exp.exc ? ECAUSE_ST_MISALIGN : '0;
      end else begin
        exp = load_result(op_i, addr, rob_idx_i);
      end
      exp_wb[rob_idx_i]   = exp;
      exp_live[rob_idx_i] = 1'b1;
      outstanding++;
      issued++;
      if (issued == 1) begin
        first_acc = cycles;
      end
      if (issued == 2) begin
        check_value("second load accept gap", 1, cycles - first_acc);
      end
    end
    if (commit_i) begin
      word = pend_addr[0][ADDR_W-1:2];
      if (word < MEM_WORDS) begin
        model_mem[word] = pend_data[0];
      end
      pend_addr.delete(0);
      pend_data.delete(0);
    end
    if (wb_s) begin
      if (!exp_live[wb_val.rob_idx]) begin
        $display("writeback for ROB index %0d with no op outstanding", wb_val.rob_idx);
        abort_run();
      end
      exp = exp_wb[wb_val.rob_idx];
      check_value($sformatf("wb data rob %0d", wb_val.rob_idx), exp.data, wb_val.data);
      check_value($sformatf("wb exc rob %0d", wb_val.rob_idx), exp.exc, wb_val.exc);
      check_value($sformatf("wb cause rob %0d", wb_val.rob_idx), exp.cause, wb_val.cause);
      exp_live[wb_val.rob_idx] = 1'b0;
      outstanding--;
      if (store_busy && wb_val.rob_idx == store_rob) begin
        store_busy = 1'b0;
        if (!exp.exc) begin
          pend_addr.push_back(store_addr);
          pend_data.push_back(store_data);
        end
      end
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic new_request();
    lsu_op_e           op;
    logic [31:0]       pick;
    logic [31:0]       word;
    logic [1:0]        boff;
    logic [ADDR_W-1:0] addr;
    pick = $random(seed);
    if (sent < 2) begin
      op   = LSU_LW;
      word = sent + 1;
      boff = 2'd0;
    end else begin
      op = lsu_op_e'(pick[1:0]);
      if (op == LSU_SW && (outstanding != 0 || pend_addr.size() >= SB_DEPTH)) begin
        op = LSU_LW;
      end
      word = (pick[7:3] < 28) ? pick[7:3] % 12 : MEM_WORDS + pick[7:3];
      if (op == LSU_LB || op == LSU_LBU) begin
        boff = pick[9:8];
      end else begin
        boff = (pick[12:10] == 3'd0) ? (pick[9:8] | 2'b01) : 2'b00;
      end
    end
    addr        = {word[ADDR_W-3:0], boff};
    base_i      = $random(seed);
    offset_i    = {{(XLEN-ADDR_W){1'b0}}, addr} - base_i;
    st_data_i   = $random(seed);
    op_i        = op;
    rob_idx_i   = rob_next;
    sb_id_i     = slot_next;
    req_valid_i = 1'b1;
    if (op == LSU_SW) begin
      store_busy = 1'b1;
      store_rob  = rob_next;
      store_addr = addr;
      store_data = st_data_i;
      if (boff == 2'b00) begin
        slot_next++;
      end
    end
    rob_next++;
    sent++;
  endtask

  task automatic choose_stimulus();
    if (issued == 2 && wb_hold) begin
      wb_hold     = 1'b0;
      check_ready = 1'b1;
    end
    if (acc_s || !req_valid_i) begin
      req_valid_i = 1'b0;
      if (sent < N_OPS && !store_busy && (sent < 2 || ($random(seed) & 1))) begin
        new_request();
      end
    end
    commit_i   = (pend_addr.size() != 0) && (($random(seed) & 3) == 0);
    wb_ready_i = wb_hold ? 1'b0 : 1'($random(seed) & 1);
  endtask

  task automatic sample_outputs();
    acc_s          = req_valid_i && req_ready_o;
    wb_s           = wb_valid_o && wb_ready_i;
    wb_val.rob_idx = wb_rob_idx_o;
    wb_val.data    = wb_data_o;
    wb_val.exc     = wb_exc_o;
    wb_val.cause   = wb_cause_o;
    if (check_ready) begin
      check_ready = 1'b0;
      check_value("ready with both lanes busy", 0, req_ready_o);
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d ops outstanding", cycles, outstanding);
      abort_run();
    end
    if (i_dut.u_asserts.fail_seen) begin
      $display("concurrent assertion failed before cycle %0d", cycles);
      abort_run();
    end
    process_events();
    choose_stimulus();
    // Outputs settle and stay until the next rising edge
    #1;
    sample_outputs();
  endtask

  initial begin
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    op_i        = LSU_LW;
    base_i      = '0;
    offset_i    = '0;
    st_data_i   = '0;
    rob_idx_i   = '0;
    sb_id_i     = '0;
    commit_i    = 1'b0;
    wb_ready_i  = 1'b0;
    foreach (model_mem[i]) begin
      model_mem[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_value("req ready after reset", 1, req_ready_o);
    check_value("wb valid after reset", 0, wb_valid_o);
    while (!(issued == N_OPS && outstanding == 0)) begin
      run_cycle();
    end
    // All lanes drained, nothing left to write back
    check_value("wb valid at end", 0, wb_valid_o);
    check_value("req ready at end", 1, req_ready_o);
    if (i_dut.u_asserts.fail_seen) begin
      $display("concurrent assertion failed during the run");
      abort_run();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- flist.f
common/lsu_pkg.sv
lsu/lsu_arbiter.sv
lsu/lsu_lane.sv
lsu/lsu_group.sv
verilog/store_buffer.sv
verilog/data_mem.sv
verilog/lsu_top.sv
verif/lsu_top_asserts.sv
verif/tb_lsu_top.sv
